//--- common/rv_pkg.sv
// shared core and memory map definitions
package rv_pkg;

    // data and address width
    localparam int unsigned XLEN = 32;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 codes
    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;
    localparam logic [2:0] F3_LW_SW = 3'b010;

    // funct7 codes telling add from sub
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // everything from here up is a pseudo peripheral
    localparam logic [XLEN-1:0] MMIO_BASE = 32'h2000_0000;

    // test status register, the signature below means passed
    localparam logic [XLEN-1:0] STATUS_ADDR = 32'h2000_0000;

    // exit register, a write ends the program
    localparam logic [XLEN-1:0] EXIT_ADDR = 32'h2000_0004;

    localparam logic [XLEN-1:0] PASS_SIGNATURE = 32'd123456789;

endpackage

//--- mm_ram/dp_ram.sv
// word ram with two registered ports
module dp_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  logic                      clk_i,

    // instruction read port
    input  logic [RAM_ADDR_WIDTH-3:0] ia_addr_i,
    output logic [rv_pkg::XLEN-1:0]   ia_rdata_o,

    // data and program load port
    input  logic                      db_en_i,
    input  logic                      db_we_i,
    input  logic [RAM_ADDR_WIDTH-3:0] db_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   db_wdata_i,
    output logic [rv_pkg::XLEN-1:0]   db_rdata_o
);
    import rv_pkg::*;

    localparam int unsigned WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    logic [XLEN-1:0] mem [WORDS];

    // instruction side reads every cycle
    always_ff @(posedge clk_i) begin
        ia_rdata_o <= mem[ia_addr_i];
    end

    // read data is left untouched on a write
    always_ff @(posedge clk_i) begin
        if (db_en_i) begin
            if (db_we_i) begin
                mem[db_addr_i] <= db_wdata_i;
            end else begin
                db_rdata_o <= mem[db_addr_i];
            end
        end
    end

endmodule

//--- mm_ram/mm_ram.sv
// ram and pseudo peripheral bus responder
module mm_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic                      instr_req_i,
    input  logic [rv_pkg::XLEN-1:0]   instr_addr_i,
    output logic                      instr_gnt_o,
    output logic                      instr_rvalid_o,
    output logic [rv_pkg::XLEN-1:0]   instr_rdata_o,

    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  logic [rv_pkg::XLEN-1:0]   data_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   data_wdata_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output logic [rv_pkg::XLEN-1:0]   data_rdata_o,

    input  logic                      prog_we_i,
    input  logic [RAM_ADDR_WIDTH-3:0] prog_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   prog_wdata_i,

    output logic                      tests_passed_o,
    output logic                      tests_failed_o,
    output logic                      exit_valid_o,
    output logic [rv_pkg::XLEN-1:0]   exit_value_o
);
    import rv_pkg::*;

    logic                      data_is_periph;
    logic                      data_fire;
    logic                      periph_we;

    logic                      ram_en;
    logic                      ram_we;
    logic [RAM_ADDR_WIDTH-3:0] ram_addr;
    logic [XLEN-1:0]           ram_wdata;
    logic [XLEN-1:0]           ram_rdata;

    logic                      instr_rvalid_q;
    logic                      data_rvalid_q;
    logic                      was_periph_q;
    logic                      was_write_q;
    logic                      passed_q;
    logic                      failed_q;
    logic                      exit_valid_q;
    logic [XLEN-1:0]           exit_value_q;

    // never stalls, every request is granted at once
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    assign data_is_periph = (data_addr_i >= MMIO_BASE);
    assign data_fire      = data_req_i && data_gnt_o;
    assign periph_we      = data_fire && data_we_i && data_is_periph;

    // the load port wins over the data bus
    assign ram_en    = prog_we_i || (data_fire && !data_is_periph);
    assign ram_we    = prog_we_i || data_we_i;
    assign ram_addr  = prog_we_i ? prog_addr_i : data_addr_i[RAM_ADDR_WIDTH-1:2];
    assign ram_wdata = prog_we_i ? prog_wdata_i : data_wdata_i;

    dp_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) dp_ram_i (
        .clk_i      (clk_i),
        .ia_addr_i  (instr_addr_i[RAM_ADDR_WIDTH-1:2]),
        .ia_rdata_o (instr_rdata_o),
        .db_en_i    (ram_en),
        .db_we_i    (ram_we),
        .db_addr_i  (ram_addr),
        .db_wdata_i (ram_wdata),
        .db_rdata_o (ram_rdata)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
            passed_q       <= 1'b0;
            failed_q       <= 1'b0;
            exit_valid_q   <= 1'b0;
            exit_value_q   <= '0;
        end else begin
            instr_rvalid_q <= instr_req_i && instr_gnt_o;
            data_rvalid_q  <= data_fire;
            // exit is a one cycle pulse per write
            exit_valid_q   <= periph_we && (data_addr_i == EXIT_ADDR);
            if (periph_we && data_addr_i == EXIT_ADDR) begin
                exit_value_q <= data_wdata_i;
            end
            // status flags stay set until reset
            if (periph_we && data_addr_i == STATUS_ADDR) begin
                if (data_wdata_i == PASS_SIGNATURE) begin
                    passed_q <= 1'b1;
                end else begin
                    failed_q <= 1'b1;
                end
            end
        end
    end

    // remembers where the last data access went
    always_ff @(posedge clk_i) begin
        if (data_fire) begin
            was_periph_q <= data_is_periph;
            was_write_q  <= data_we_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rvalid_o  = data_rvalid_q;
    assign data_rdata_o   = (was_periph_q || was_write_q) ? '0 : ram_rdata;

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

endmodule

//--- core/rv_core.sv
// multi-cycle rv32i subset core
module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] BOOT_ADDR = 32'h80
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    fetch_enable_i,

    output logic                    instr_req_o,
    output logic [rv_pkg::XLEN-1:0] instr_addr_o,
    input  logic                    instr_gnt_i,
    input  logic                    instr_rvalid_i,
    input  logic [rv_pkg::XLEN-1:0] instr_rdata_i,

    output logic                    data_req_o,
    output logic                    data_we_o,
    output logic [rv_pkg::XLEN-1:0] data_addr_o,
    output logic [rv_pkg::XLEN-1:0] data_wdata_o,
    input  logic                    data_gnt_i,
    input  logic                    data_rvalid_i,
    input  logic [rv_pkg::XLEN-1:0] data_rdata_i
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT_I,
        S_EXEC,
        S_MEM,
        S_WAIT_D
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] ir_q;

    // x0 is never written, reads of it are forced to zero
    logic [XLEN-1:0] regs [32];

    logic [6:0]      opcode;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    logic            alu_we;
    logic [XLEN-1:0] alu_res;
    logic            mem_op;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;

    logic            rf_we;
    logic [XLEN-1:0] rf_wdata;

    logic            data_we_q;
    logic [XLEN-1:0] data_addr_q;
    logic [XLEN-1:0] data_wdata_q;

    assign opcode = ir_q[6:0];
    assign rd     = ir_q[11:7];
    assign funct3 = ir_q[14:12];
    assign rs1    = ir_q[19:15];
    assign rs2    = ir_q[24:20];
    assign funct7 = ir_q[31:25];

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // immediate decoder
    assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
    assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
    assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
    assign imm_u = {ir_q[31:12], 12'b0};
    assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

    assign pc_plus4 = pc_q + XLEN'(4);

    // execute stage, unknown encodings fall through as a no-op
    always_comb begin
        alu_we   = 1'b0;
        alu_res  = '0;
        mem_op   = 1'b0;
        mem_we   = 1'b0;
        mem_addr = rs1_val + imm_i;
        pc_next  = pc_plus4;
        case (opcode)
            OPC_LUI: begin
                alu_we  = 1'b1;
                alu_res = imm_u;
            end
            OPC_OPIMM: begin
                if (funct3 == F3_ADD) begin
                    alu_we  = 1'b1;
                    alu_res = rs1_val + imm_i;
                end
            end
            OPC_OP: begin
                if (funct3 == F3_ADD && funct7 == F7_ADD) begin
                    alu_we  = 1'b1;
                    alu_res = rs1_val + rs2_val;
                end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    alu_we  = 1'b1;
                    alu_res = rs1_val - rs2_val;
                end
            end
            OPC_LOAD: begin
                mem_op = (funct3 == F3_LW_SW);
            end
            OPC_STORE: begin
                mem_op   = (funct3 == F3_LW_SW);
                mem_we   = 1'b1;
                mem_addr = rs1_val + imm_s;
            end
            OPC_BRANCH: begin
                if ((funct3 == F3_BEQ && rs1_val == rs2_val) ||
                    (funct3 == F3_BNE && rs1_val != rs2_val)) begin
                    pc_next = pc_q + imm_b;
                end
            end
            OPC_JAL: begin
                // link register gets the return address
                alu_we  = 1'b1;
                alu_res = pc_plus4;
                pc_next = pc_q + imm_j;
            end
            default: begin
                alu_we = 1'b0;
            end
        endcase
    end

    // single write port, alu results in execute and load data on rvalid
    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = alu_res;
        if (state_q == S_EXEC) begin
            rf_we = alu_we;
        end else if (state_q == S_WAIT_D && data_rvalid_i && !data_we_q) begin
            rf_we    = 1'b1;
            rf_wdata = data_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rf_we && rd != 5'd0) begin
            regs[rd] <= rf_wdata;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH:  if (instr_req_o && instr_gnt_i) state_d = S_WAIT_I;
            S_WAIT_I: if (instr_rvalid_i) state_d = S_EXEC;
            S_EXEC:   state_d = mem_op ? S_MEM : S_FETCH;
            S_MEM:    if (data_gnt_i) state_d = S_WAIT_D;
            S_WAIT_D: if (data_rvalid_i) state_d = S_FETCH;
            default:  state_d = S_FETCH;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_FETCH;
            pc_q    <= BOOT_ADDR;
        end else begin
            state_q <= state_d;
            if (state_q == S_EXEC) begin
                pc_q <= pc_next;
            end
        end
    end

    // instruction word and data access are captured once and held
    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT_I && instr_rvalid_i) begin
            ir_q <= instr_rdata_i;
        end
        if (state_q == S_EXEC) begin
            data_we_q    <= mem_we;
            data_addr_q  <= mem_addr;
            data_wdata_q <= rs2_val;
        end
    end

    assign instr_req_o  = (state_q == S_FETCH) && fetch_enable_i;
    assign instr_addr_o = pc_q;

    assign data_req_o   = (state_q == S_MEM);
    assign data_we_o    = data_we_q;
    assign data_addr_o  = data_addr_q;
    assign data_wdata_o = data_wdata_q;

endmodule

//--- src/riscv_wrapper.sv
// core and memory subsystem top level
module riscv_wrapper #(
    parameter int unsigned             RAM_ADDR_WIDTH = 12,
    parameter logic [rv_pkg::XLEN-1:0] BOOT_ADDR      = 32'h80
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      fetch_enable_i,

    // boot loader, only while the core is in reset
    input  logic                      prog_we_i,
    input  logic [RAM_ADDR_WIDTH-3:0] prog_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   prog_wdata_i,

    output logic                      tests_passed_o,
    output logic                      tests_failed_o,
    output logic                      exit_valid_o,
    output logic [rv_pkg::XLEN-1:0]   exit_value_o
);
    import rv_pkg::*;

    // instruction bus
    logic            instr_req;
    logic            instr_gnt;
    logic            instr_rvalid;
    logic [XLEN-1:0] instr_addr;
    logic [XLEN-1:0] instr_rdata;

    // data bus
    logic            data_req;
    logic            data_gnt;
    logic            data_rvalid;
    logic            data_we;
    logic [XLEN-1:0] data_addr;
    logic [XLEN-1:0] data_wdata;
    logic [XLEN-1:0] data_rdata;

    rv_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) riscv_core_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata),
        .data_req_o     (data_req),
        .data_we_o      (data_we),
        .data_addr_o    (data_addr),
        .data_wdata_o   (data_wdata),
        .data_gnt_i     (data_gnt),
        .data_rvalid_i  (data_rvalid),
        .data_rdata_i   (data_rdata)
    );

    // ram plus the status and exit registers
    mm_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ram_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_we_i      (data_we),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .prog_we_i      (prog_we_i),
        .prog_addr_i    (prog_addr_i),
        .prog_wdata_i   (prog_wdata_i),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

//--- tests/mm_ram_properties.sv
// bus protocol and status checks
module mm_ram_properties (
    input logic clk_i,
    input logic reset_i,
    input logic instr_req_i,
    input logic instr_gnt_o,
    input logic instr_rvalid_o,
    input logic data_req_i,
    input logic data_gnt_o,
    input logic data_rvalid_o,
    input logic tests_passed_o,
    input logic tests_failed_o,
    input logic exit_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int violations;

    // a response follows each granted request after exactly one cycle
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_o == $past(instr_req_i && instr_gnt_o))
    else begin
        $error("instruction rvalid does not match a granted request one cycle before");
        violations++;
    end

    a_data_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
        data_rvalid_o == $past(data_req_i && data_gnt_o))
    else begin
        $error("data rvalid does not match a granted request one cycle before");
        violations++;
    end

    a_status_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(tests_passed_o && tests_failed_o))
    else begin
        $error("passed and failed are both high");
        violations++;
    end

    a_exit_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        exit_valid_o |=> !exit_valid_o)
    else begin
        $error("exit valid lasted more than one cycle");
        violations++;
    end

    a_reset_low: assert property (@(posedge clk_i)
        reset_i |=> !instr_rvalid_o && !data_rvalid_o && !tests_passed_o &&
                    !tests_failed_o && !exit_valid_o)
    else begin
        $error("outputs not low in the cycle after reset");
        violations++;
    end

endmodule

bind mm_ram mm_ram_properties props_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_req_i    (instr_req_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o)
);

//--- tests/tb_riscv_wrapper.sv
// core subsystem testbench
module tb_riscv_wrapper;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned RAM_ADDR_WIDTH  = 12;
    localparam int          CLK_PERIOD      = 40;
    localparam int          CYCLES_PER_TEST = 2000;
    localparam string       PATTERN_FILE    = "tests/program_patterns.txt";

    logic                      clk;
    logic                      reset;
    logic                      fetch_enable;
    logic                      prog_we;
    logic [RAM_ADDR_WIDTH-3:0] prog_addr;
    logic [31:0]               prog_wdata;
    logic                      tests_passed;
    logic                      tests_failed;
    logic                      exit_valid;
    logic [31:0]               exit_value;

    int n_tests;
    int errors;
    int tests_run;
    int tests_ok;

    riscv_wrapper #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .BOOT_ADDR      (32'h80)
    ) DUT (
        .clk_i          (clk),
        .reset_i        (reset),
        .fetch_enable_i (fetch_enable),
        .prog_we_i      (prog_we),
        .prog_addr_i    (prog_addr),
        .prog_wdata_i   (prog_wdata),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // counts the run records and skips comment lines
    function automatic int count_runs();
        int    fd;
        int    code;
        int    runs;
        string tag;
        string line;
        runs = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd != 0) begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    code = $fgets(line, fd);
                end else if (tag == "R") begin
                    runs++;
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
        return runs;
    endfunction

    // one word per cycle while the core sits in reset
    task automatic load_word(input logic [31:0] idx, input logic [31:0] word);
        prog_we    = 1'b1;
        prog_addr  = idx[RAM_ADDR_WIDTH-3:0];
        prog_wdata = word;
        @(posedge clk);
        #2;
        prog_we = 1'b0;
    endtask

    task automatic run_program(input string name, input logic [31:0] exp_value,
                               input logic exp_passed, input logic exp_failed);
        int errs_before;
        errs_before = errors;
        assert (!tests_passed && !tests_failed) else begin
            $display("[FAIL] %0d ns %s: status outputs not cleared by reset", $time, name);
            errors++;
        end
        reset        = 1'b0;
        fetch_enable = 1'b1;
        // program ends with its write to the exit register
        do begin
            @(posedge clk);
            #2;
        end while (!exit_valid);
        assert (exit_value == exp_value) else begin
            $display("[FAIL] %0d ns %s: exit value %h, expected %h",
                     $time, name, exit_value, exp_value);
            errors++;
        end
        assert (tests_passed == exp_passed) else begin
            $display("[FAIL] %0d ns %s: passed is %b, expected %b",
                     $time, name, tests_passed, exp_passed);
            errors++;
        end
        assert (tests_failed == exp_failed) else begin
            $display("[FAIL] %0d ns %s: failed is %b, expected %b",
                     $time, name, tests_failed, exp_failed);
            errors++;
        end
        tests_run++;
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
        end
        // back into reset so the next program can be loaded
        fetch_enable = 1'b0;
        reset        = 1'b1;
        repeat (4) @(posedge clk);
        #2;
    endtask

    initial begin : main
        int          fd;
        int          code;
        string       tag;
        string       name;
        string       line;
        logic [31:0] idx;
        logic [31:0] word;
        logic [31:0] exp_value;
        logic        exp_passed;
        logic        exp_failed;
        errors       = 0;
        tests_run    = 0;
        tests_ok     = 0;
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_enable = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_wdata   = '0;
        exp_value    = '0;
        exp_passed   = 1'b0;
        exp_failed   = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        n_tests = count_runs();
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0 || n_tests == 0) begin
            $display("patterns file %s is missing or holds no tests", PATTERN_FILE);
            errors++;
        end else begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    code = $fgets(line, fd);
                end else if (tag == "P") begin
                    code = $fscanf(fd, "%h %h", idx, word);
                    load_word(idx, word);
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %d %d", exp_value, exp_passed, exp_failed);
                end else if (tag == "R") begin
                    code = $fscanf(fd, "%s", name);
                    run_program(name, exp_value, exp_passed, exp_failed);
                end else begin
                    $display("unknown record '%s' in the patterns file", tag);
                    errors++;
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
        $display("tests run %0d, passed %0d, failed %0d, protocol assertion failures %0d",
                 tests_run, tests_ok, tests_run - tests_ok, DUT.ram_i.props_i.violations);
        if (errors == 0 && DUT.ram_i.props_i.violations == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // generous budget per test that covers the program load as well
    initial begin : watchdog
        wait (n_tests > 0);
        #(n_tests * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles per test",
                 CYCLES_PER_TEST);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- tests/program_patterns.txt
# P <word index hex> <instruction hex>, E <exit value hex> <passed> <failed>
# programs start at byte 0x80 (word 0x20), a run record starts the test
# lui, addi, add, sub and an addi to x0, exit 0x12345678
P 20 123450B7
P 21 67808093
P 22 FFB00113
P 23 002081B3
P 24 40118233
P 25 00700013
P 26 00018533
P 27 40450533
P 28 200002B7
P 29 00A2A223
P 2A 0000006F
E 12345678 0 0
R arith
# store 0xCAFEBABE at byte 0x208, load it back
P 20 CAFEC0B7
P 21 ABE08093
P 22 20000113
P 23 00112423
P 24 00812503
P 25 200002B7
P 26 00A2A223
P 27 0000006F
E CAFEBABE 0 0
R load_store
# bne loop sums 10 down to 1, beq not taken falls into the copy
P 20 00000513
P 21 00000093
P 22 00A00113
P 23 002080B3
P 24 FFF10113
P 25 FE011CE3
P 26 00008463
P 27 00008513
P 28 200002B7
P 29 00A2A223
P 2A 0000006F
E 37 0 0
R branch
# jal at 0x84 skips two words, link is 0x88
P 20 00000513
P 21 00C000EF
P 22 00100093
P 23 00100093
P 24 00008513
P 25 200002B7
P 26 00A2A223
P 27 0000006F
E 88 0 0
R jal
# pass signature 123456789 then exit 0x5A
P 20 200002B7
P 21 075BD337
P 22 D1530313
P 23 0062A023
P 24 05A00513
P 25 00A2A223
P 26 0000006F
E 5A 1 0
R pass_sig
# status and exit both get 0xBD
P 20 200002B7
P 21 0BD00313
P 22 0062A023
P 23 0062A223
P 24 0000006F
E BD 0 1
R fail_sig
# no load, the program left in ram runs again after reset
E BD 0 1
R fail_rerun

//--- all.f
common/rv_pkg.sv
mm_ram/dp_ram.sv
mm_ram/mm_ram.sv
core/rv_core.sv
src/riscv_wrapper.sv
tests/mm_ram_properties.sv
tests/tb_riscv_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_wrapper
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
